// File: bench/mem_bridge_props.sv
module mem_bridge_props import bridge_pkg::*; (
    input logic     clk_i,
    input logic     rst_n_i,
    input logic     valid_i,
    input logic     ready_i,
    input data_t    payload_i,
    input logic     last_i,
    input axi_len_t len_i,
    input logic     count_last_i  // only the W channel has a last flag
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;
    axi_len_t    beat_q;  // beats accepted in the current burst

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            beat_q <= '0;
        end else if (valid_i && ready_i) begin
            beat_q <= last_i ? '0 : beat_q + 8'd1;
        end
    end

    hold_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && !ready_i |=> valid_i)
    else begin
        fail_cnt++;
        $error("valid dropped before ready");
    end

    hold_payload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && !ready_i |=> $stable(payload_i))
    else begin
        fail_cnt++;
        $error("payload changed while waiting for ready");
    end

    last_on_final: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_last_i && valid_i && ready_i |-> (last_i == (beat_q == len_i)))
    else begin
        fail_cnt++;
        $error("wlast not on beat len+1");
    end

endmodule

bind axi_bus_mux mem_bridge_props ar_chk (
    .clk_i(aclk), .rst_n_i(rst_n_i), .valid_i(arvalid_o), .ready_i(arready_i),
    .payload_i(araddr_o), .last_i(1'b0), .len_i(arlen_o), .count_last_i(1'b0)
);

bind data_access_port mem_bridge_props w_chk (
    .clk_i(aclk), .rst_n_i(rst_n_i), .valid_i(wvalid_o), .ready_i(wready_i),
    .payload_i(wdata_o), .last_i(wlast_o), .len_i(awlen_o), .count_last_i(1'b1)
);

// File: bench/mem_bridge_tb.sv
module mem_bridge_tb import bridge_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int         LEN_W       = 4;
    localparam int         NUM_TESTS   = 9;
    localparam int         TEST_CYCLES = 200;
    localparam logic [1:0] P_FETCH     = 2'd0;
    localparam logic [1:0] P_DATA      = 2'd1;
    localparam logic [1:0] P_BOTH      = 2'd2;
    localparam data_t      RD_MASK     = 32'hA5A5_0000;
    localparam addr_t      BOTH_OFS    = 32'h0000_0800;  // data address in joint tests

    typedef struct packed {
        logic [1:0]       port;
        logic             we;
        logic             bp;     // random ready back-pressure
        addr_t            addr;
        logic [LEN_W-1:0] len;
        data_t            wbase;  // first write word then +1 per beat
    } test_t;

    test_t tbl [NUM_TESTS];
    string names [NUM_TESTS];

    logic             clk, rst_n_i;
    logic             fetch_req_i, fetch_ready_o, fetch_data_valid_o, fetch_done_o;
    logic             mem_req_i, mem_we_i, mem_ready_o, wdata_pull_o;
    logic             mem_rdata_valid_o, mem_done_o;
    logic [LEN_W-1:0] fetch_len_i, mem_len_i;
    addr_t            fetch_addr_i, mem_addr_i, araddr_o, awaddr_o;
    data_t            fetch_data_o, mem_wdata_i, mem_rdata_o, rdata_i, wdata_o;
    strb_t            mem_wstrb_i, wstrb_o;
    axi_id_t          arid_o, rid_i, awid_o, bid_i;
    axi_len_t         arlen_o, awlen_o;
    logic             arvalid_o, arready_i, rlast_i, rvalid_i, rready_o;
    logic             awvalid_o, awready_i, wlast_o, wvalid_o, wready_i;
    logic             bvalid_i, bready_o;

    // slave model state and transfer logs
    logic     bp_on;
    axi_id_t  pend_id [$];
    addr_t    pend_addr [$];
    axi_len_t pend_len [$];
    axi_id_t  ar_log_id [$];
    addr_t    ar_log_addr [$];
    axi_len_t ar_log_len [$];
    axi_id_t  aw_log_id [$];
    addr_t    aw_log_addr [$];
    axi_len_t aw_log_len [$];
    data_t    w_log_data [$];
    strb_t    w_log_strb [$];
    logic     w_log_last [$];
    int       errors;
    int       tests_failed;
    int       asrt_fails;

    tb_clock #(.PERIOD_NS(8)) clock_gen (.clk_o(clk));

    mem_bridge_top #(.MAX_LEN_W(LEN_W)) mem_bridge_top_i (.aclk(clk), .*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_data(input string name, input string what, input data_t exp,
                              input data_t act);
        if (exp !== act) begin
            $display("ERR %s %s exp=%h act=%h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input string what, input addr_t exp,
                              input addr_t act);
        if (exp !== act) begin
            $display("ERR %s %s exp=%h act=%h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_id(input string name, input string what, input axi_id_t exp,
                            input axi_id_t act);
        if (exp !== act) begin
            $display("ERR %s %s exp=%h act=%h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_strb(input string name, input string what, input strb_t exp,
                              input strb_t act);
        if (exp !== act) begin
            $display("ERR %s %s exp=%h act=%h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_len(input string name, input string what, input axi_len_t exp,
                             input axi_len_t act);
        if (exp !== act) begin
            $display("ERR %s %s exp=%0d act=%0d", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (exp !== act) begin
            $display("ERR %s %s exp=%b act=%b", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp,
                               input int act);
        if (exp != act) begin
            $display("ERR %s %s exp=%0d act=%0d", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - err0);
            tests_failed++;
        end
    endtask

    // AXI slave answering read bursts in order one at a time
    initial begin : slave_model
        logic [31:0] rnd;
        int          beat;
        logic        b_due;
        rnd       = 32'h738b_f56a;
        beat      = 0;
        b_due     = 1'b0;
        arready_i = 1'b0;
        awready_i = 1'b0;
        wready_i  = 1'b0;
        rvalid_i  = 1'b0;
        rid_i     = '0;
        rdata_i   = '0;
        rlast_i   = 1'b0;
        bvalid_i  = 1'b0;
        bid_i     = ID_DATA;
        forever begin
            @(negedge clk);
            if (arvalid_o && arready_i) begin
                pend_id.push_back(arid_o);
                pend_addr.push_back(araddr_o);
                pend_len.push_back(arlen_o);
                ar_log_id.push_back(arid_o);
                ar_log_addr.push_back(araddr_o);
                ar_log_len.push_back(arlen_o);
            end
            if (rvalid_i && rlast_i) begin  // rready is tied high
                void'(pend_id.pop_front());
                void'(pend_addr.pop_front());
                void'(pend_len.pop_front());
                beat = 0;
            end else if (rvalid_i) begin
                beat++;
            end
            if (awvalid_o && awready_i) begin
                aw_log_id.push_back(awid_o);
                aw_log_addr.push_back(awaddr_o);
                aw_log_len.push_back(awlen_o);
            end
            if (wvalid_o && wready_i) begin
                w_log_data.push_back(wdata_o);
                w_log_strb.push_back(wstrb_o);
                w_log_last.push_back(wlast_o);
                if (wlast_o) b_due = 1'b1;
            end
            @(posedge clk);
            #1;
            rnd       = xorshift32(rnd);
            arready_i = !bp_on || rnd[0];
            awready_i = !bp_on || rnd[1];
            wready_i  = !bp_on || rnd[2];
            rvalid_i  = 1'b0;
            if (pend_id.size() > 0 && (!bp_on || rnd[3])) begin
                rvalid_i = 1'b1;
                rid_i    = pend_id[0];
                rdata_i  = (pend_addr[0] + 32'(4 * beat)) ^ RD_MASK;
                rlast_i  = (beat == int'(pend_len[0]));
            end
            if (bvalid_i) begin
                bvalid_i = 1'b0;  // bready is tied high
            end else if (b_due && (!bp_on || rnd[4])) begin
                bvalid_i = 1'b1;
                b_due    = 1'b0;
            end
        end
    end

    task automatic run_test(input int t);
        test_t tc;
        string nm;
        addr_t d_addr;
        data_t f_got [$];
        data_t d_got [$];
        int    err0, cyc, ar0, aw0, w0, widx, nf, nd, n;
        logic  f_wait, d_wait, pull;
        tc     = tbl[t];
        nm     = names[t];
        err0   = errors;
        ar0    = ar_log_id.size();
        aw0    = aw_log_addr.size();
        w0     = w_log_data.size();
        d_addr = (tc.port == P_BOTH) ? tc.addr + BOTH_OFS : tc.addr;
        f_wait = (tc.port != P_DATA);
        d_wait = (tc.port != P_FETCH);
        n      = int'(tc.len) + 1;
        bp_on  = tc.bp;
        @(posedge clk);
        #1;
        widx         = 0;
        fetch_req_i  = f_wait;
        fetch_addr_i = tc.addr;
        fetch_len_i  = tc.len;
        mem_req_i    = d_wait;
        mem_we_i     = tc.we;
        mem_addr_i   = d_addr;
        mem_len_i    = tc.len;
        mem_wdata_i  = tc.wbase;
        mem_wstrb_i  = 4'hF;
        cyc          = 0;
        while ((f_wait || d_wait) && cyc < TEST_CYCLES) begin
            @(negedge clk);
            if (fetch_data_valid_o) f_got.push_back(fetch_data_o);
            if (mem_rdata_valid_o) d_got.push_back(mem_rdata_o);
            if (rvalid_i) check_bit(nm, "rready_o", 1'b1, rready_o);
            if (bvalid_i) check_bit(nm, "bready_o", 1'b1, bready_o);
            if (fetch_done_o) begin
                check_bit(nm, "last fetch beat with fetch done", 1'b1,
                          rvalid_i && rlast_i && rid_i == ID_FETCH);
                f_wait = 1'b0;
            end
            if (mem_done_o) begin
                check_bit(nm, "cause of data done", 1'b1,
                          tc.we ? bvalid_i : (rvalid_i && rlast_i && rid_i == ID_DATA));
                d_wait = 1'b0;
            end
            pull = wdata_pull_o;
            @(posedge clk);
            #1;
            fetch_req_i = 1'b0;
            mem_req_i   = 1'b0;
            if (pull) begin  // cache presents the next word
                widx++;
                mem_wdata_i = tc.wbase + 32'(widx);
                mem_wstrb_i = ~strb_t'(widx);
            end
            cyc++;
        end
        if (f_wait || d_wait) begin
            $display("test %s: no done pulse within %0d cycles", nm, TEST_CYCLES);
            errors++;
        end
        check_count(nm, "fetch beats", (tc.port != P_DATA) ? n : 0, f_got.size());
        foreach (f_got[k]) begin
            check_data(nm, $sformatf("fetch word %0d", k),
                       (tc.addr + 32'(4 * k)) ^ RD_MASK, f_got[k]);
        end
        check_count(nm, "read beats", (!tc.we && tc.port != P_FETCH) ? n : 0,
                    d_got.size());
        foreach (d_got[k]) begin
            check_data(nm, $sformatf("read word %0d", k),
                       (d_addr + 32'(4 * k)) ^ RD_MASK, d_got[k]);
        end
        nf = 0;
        nd = 0;
        for (int k = ar0; k < ar_log_id.size(); k++) begin
            if (ar_log_id[k] == ID_DATA) begin
                nd++;
                check_addr(nm, "data araddr", d_addr, ar_log_addr[k]);
            end else begin
                nf++;
                check_id(nm, "arid", ID_FETCH, ar_log_id[k]);
                check_addr(nm, "fetch araddr", tc.addr, ar_log_addr[k]);
            end
            check_len(nm, "arlen", axi_len_t'(tc.len), ar_log_len[k]);
        end
        check_count(nm, "fetch AR bursts", (tc.port != P_DATA) ? 1 : 0, nf);
        check_count(nm, "data AR bursts", (tc.port != P_FETCH && !tc.we) ? 1 : 0, nd);
        check_count(nm, "AW bursts", tc.we ? 1 : 0, aw_log_addr.size() - aw0);
        for (int k = aw0; k < aw_log_addr.size(); k++) begin
            check_id(nm, "awid", ID_DATA, aw_log_id[k]);
            check_addr(nm, "awaddr", d_addr, aw_log_addr[k]);
            check_len(nm, "awlen", axi_len_t'(tc.len), aw_log_len[k]);
        end
        check_count(nm, "W beats", tc.we ? n : 0, w_log_data.size() - w0);
        for (int k = w0; k < w_log_data.size(); k++) begin
            check_data(nm, $sformatf("wdata beat %0d", k - w0),
                       tc.wbase + 32'(k - w0), w_log_data[k]);
            check_strb(nm, $sformatf("wstrb beat %0d", k - w0),
                       ~strb_t'(k - w0), w_log_strb[k]);
            check_bit(nm, $sformatf("wlast beat %0d", k - w0),
                      (k - w0) == int'(tc.len), w_log_last[k]);
        end
        report_test(nm, err0);
    endtask

    initial begin : watchdog
        repeat (NUM_TESTS * TEST_CYCLES + 50) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        int err0;
        rst_n_i      = 1'b0;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        fetch_len_i  = '0;
        mem_req_i    = 1'b0;
        mem_we_i     = 1'b0;
        mem_addr_i   = '0;
        mem_len_i    = '0;
        mem_wdata_i  = '0;
        mem_wstrb_i  = '0;
        bp_on        = 1'b0;
        errors       = 0;
        tests_failed = 0;
        tbl[0] = '{P_FETCH, 1'b0, 1'b0, 32'h0000_1000, 4'd3, 32'h0};
        names[0] = "fetch_len3";
        tbl[1] = '{P_DATA, 1'b0, 1'b0, 32'h0000_2040, 4'd1, 32'h0};
        names[1] = "data_read_len1";
        tbl[2] = '{P_DATA, 1'b1, 1'b0, 32'h0000_3000, 4'd3, 32'h1111_0000};
        names[2] = "data_write_len3";
        tbl[3] = '{P_BOTH, 1'b0, 1'b0, 32'h0000_4000, 4'd2, 32'h0};
        names[3] = "both_read_len2";
        tbl[4] = '{P_FETCH, 1'b0, 1'b1, 32'h0000_1100, 4'd7, 32'h0};
        names[4] = "fetch_bp_len7";
        tbl[5] = '{P_DATA, 1'b0, 1'b1, 32'h0000_2200, 4'd15, 32'h0};
        names[5] = "data_read_bp_len15";
        tbl[6] = '{P_DATA, 1'b1, 1'b1, 32'h0000_3300, 4'd5, 32'h2222_0000};
        names[6] = "data_write_bp_len5";
        tbl[7] = '{P_BOTH, 1'b0, 1'b1, 32'h0000_5000, 4'd4, 32'h0};
        names[7] = "both_read_bp_len4";
        tbl[8] = '{P_DATA, 1'b1, 1'b1, 32'h0000_3400, 4'd0, 32'h3333_0000};
        names[8] = "data_write_bp_len0";
        repeat (5) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        err0 = errors;
        check_bit("reset", "arvalid_o", 1'b0, arvalid_o);
        check_bit("reset", "awvalid_o", 1'b0, awvalid_o);
        check_bit("reset", "wvalid_o", 1'b0, wvalid_o);
        check_bit("reset", "fetch_done_o", 1'b0, fetch_done_o);
        check_bit("reset", "mem_done_o", 1'b0, mem_done_o);
        check_bit("reset", "fetch_ready_o", 1'b1, fetch_ready_o);
        check_bit("reset", "mem_ready_o", 1'b1, mem_ready_o);
        check_bit("reset", "rready_o", 1'b1, rready_o);
        check_bit("reset", "bready_o", 1'b1, bready_o);
        report_test("reset", err0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        asrt_fails = int'(mem_bridge_top_i.u_mux.ar_chk.fail_cnt)
                   + int'(mem_bridge_top_i.u_data.w_chk.fail_cnt);
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 NUM_TESTS + 1, tests_failed, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o;  // 50 % duty

endmodule

// File: mem_bridge_top.f
src/bridge_pkg.sv
src/refill_read_port.sv
src/data_access_port.sv
src/axi_bus_mux.sv
src/mem_bridge_top.sv
bench/tb_clock.sv
bench/mem_bridge_props.sv
bench/mem_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator, pass only if the log shows the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module mem_bridge_tb -Mdir build -f mem_bridge_top.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./build/Vmem_bridge_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// File: src/axi_bus_mux.sv
module axi_bus_mux import bridge_pkg::*; (
    input  logic     aclk,
    input  logic     rst_n_i,
    // refill port request
    input  logic     fetch_ar_valid_i,
    input  addr_t    fetch_ar_addr_i,
    input  axi_len_t fetch_ar_len_i,
    output logic     fetch_grant_o,
    output logic     fetch_beat_valid_o,
    output data_t    fetch_beat_data_o,
    output logic     fetch_beat_last_o,
    // data port request
    input  logic     data_ar_valid_i,
    input  addr_t    data_ar_addr_i,
    input  axi_len_t data_ar_len_i,
    output logic     data_grant_o,
    output logic     data_beat_valid_o,
    output data_t    data_beat_data_o,
    output logic     data_beat_last_o,
    // AXI read address
    output axi_id_t  arid_o,
    output addr_t    araddr_o,
    output axi_len_t arlen_o,
    output logic     arvalid_o,
    input  logic     arready_i,
    // AXI read data
    input  axi_id_t  rid_i,
    input  data_t    rdata_i,
    input  logic     rlast_i,
    input  logic     rvalid_i,
    output logic     rready_o
);

    logic last_data_q;  // previous grant went to the data port
    logic hold_q;       // AR offered but not yet taken
    logic hold_data_q;
    logic pick_data;
    logic sel_data;
    logic ar_fire;

    // round robin, the loser of the last conflict goes first
    assign pick_data = data_ar_valid_i & (~fetch_ar_valid_i | ~last_data_q);
    // keep the choice stable while arready is low
    assign sel_data  = hold_q ? hold_data_q : pick_data;

    assign arvalid_o = sel_data ? data_ar_valid_i : fetch_ar_valid_i;
    assign araddr_o  = sel_data ? data_ar_addr_i : fetch_ar_addr_i;
    assign arlen_o   = sel_data ? data_ar_len_i : fetch_ar_len_i;
    assign arid_o    = sel_data ? ID_DATA : ID_FETCH;

    assign ar_fire       = arvalid_o & arready_i;
    assign fetch_grant_o = ar_fire & ~sel_data;
    assign data_grant_o  = ar_fire & sel_data;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            last_data_q <= 1'b0;
            hold_q      <= 1'b0;
            hold_data_q <= 1'b0;
        end else if (ar_fire) begin
            last_data_q <= sel_data;
            hold_q      <= 1'b0;
        end else if (arvalid_o) begin
            hold_q      <= 1'b1;
            hold_data_q <= sel_data;
        end
    end

    // caches never stall the R channel
    assign rready_o = 1'b1;

    // steer beats back by ID
    assign fetch_beat_valid_o = rvalid_i & (rid_i == ID_FETCH);
    assign fetch_beat_data_o  = rdata_i;
    assign fetch_beat_last_o  = rlast_i;
    assign data_beat_valid_o  = rvalid_i & (rid_i == ID_DATA);
    assign data_beat_data_o   = rdata_i;
    assign data_beat_last_o   = rlast_i;

endmodule

// File: src/bridge_pkg.sv
package bridge_pkg;

    // bus payload widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // AXI burst length, beats minus one
    typedef logic [7:0]  axi_len_t;
    typedef logic [3:0]  axi_id_t;

    // read IDs name the requesting port
    localparam axi_id_t ID_FETCH = 4'd0;
    localparam axi_id_t ID_DATA  = 4'd1;

    // shared by both port sequencers
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ADDR = 2'd1,
        DATA = 2'd2,
        RESP = 2'd3
    } port_state_t;

endpackage

// File: src/data_access_port.sv
module data_access_port import bridge_pkg::*; #(
    parameter int MAX_LEN_W = 4
) (
    input  logic                 aclk,
    input  logic                 rst_n_i,
    // dcache / commit side
    input  logic                 mem_req_i,
    input  logic                 mem_we_i,
    input  addr_t                mem_addr_i,
    input  logic [MAX_LEN_W-1:0] mem_len_i,
    input  data_t                mem_wdata_i,
    input  strb_t                mem_wstrb_i,
    output logic                 mem_ready_o,
    output logic                 wdata_pull_o,
    output logic                 mem_rdata_valid_o,
    output data_t                mem_rdata_o,
    output logic                 mem_done_o,
    // read path through the mux
    output logic                 ar_valid_o,
    output addr_t                ar_addr_o,
    output axi_len_t             ar_len_o,
    input  logic                 ar_grant_i,
    input  logic                 beat_valid_i,
    input  data_t                beat_data_i,
    input  logic                 beat_last_i,
    // write channels, owned by this port alone
    output logic                 awvalid_o,
    output addr_t                awaddr_o,
    output axi_len_t             awlen_o,
    input  logic                 awready_i,
    output logic                 wvalid_o,
    output data_t                wdata_o,
    output strb_t                wstrb_o,
    output logic                 wlast_o,
    input  logic                 wready_i,
    input  logic                 bvalid_i
);

    port_state_t          state_q;
    port_state_t          state_d;
    logic                 we_q;
    addr_t                addr_q;
    logic [MAX_LEN_W-1:0] len_q;
    logic [MAX_LEN_W-1:0] cnt_q;   // write beats already accepted
    logic                 rd_data;
    logic                 wr_data;
    logic                 w_fire;

    assign mem_ready_o = (state_q == IDLE);
    assign rd_data     = (state_q == DATA) & ~we_q;
    assign wr_data     = (state_q == DATA) & we_q;

    // address phase, AR or AW depending on direction
    assign ar_valid_o = (state_q == ADDR) & ~we_q;
    assign awvalid_o  = (state_q == ADDR) & we_q;
    assign ar_addr_o  = addr_q;
    assign awaddr_o   = addr_q;
    assign ar_len_o   = axi_len_t'(len_q);
    assign awlen_o    = axi_len_t'(len_q);

    // cache holds the current word until it is pulled
    assign wvalid_o     = wr_data;
    assign wdata_o      = mem_wdata_i;
    assign wstrb_o      = mem_wstrb_i;
    assign wlast_o      = wr_data & (cnt_q == len_q);
    assign w_fire       = wvalid_o & wready_i;
    assign wdata_pull_o = w_fire;

    assign mem_rdata_valid_o = rd_data & beat_valid_i;
    assign mem_rdata_o       = beat_data_i;
    assign mem_done_o        = (rd_data & beat_valid_i & beat_last_i)
                             | ((state_q == RESP) & bvalid_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (mem_req_i) state_d = ADDR;
            ADDR: begin
                if (we_q ? awready_i : ar_grant_i) state_d = DATA;
            end
            DATA: begin
                if (we_q) begin
                    if (w_fire && wlast_o) state_d = RESP;
                end else if (beat_valid_i && beat_last_i) begin
                    state_d = IDLE;
                end
            end
            RESP: if (bvalid_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (mem_req_i && mem_ready_o) begin // request capture
            we_q   <= mem_we_i;
            addr_q <= mem_addr_i;
            len_q  <= mem_len_i;
            cnt_q  <= '0;
        end else if (w_fire) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n_i) state_q <= IDLE;
        else          state_q <= state_d;
    end

endmodule

// File: src/mem_bridge_top.sv
module mem_bridge_top import bridge_pkg::*; #(
    parameter int MAX_LEN_W = 4
) (
    input  logic                 aclk,
    input  logic                 rst_n_i,
    // instruction refill
    input  logic                 fetch_req_i,
    input  addr_t                fetch_addr_i,
    input  logic [MAX_LEN_W-1:0] fetch_len_i,
    output logic                 fetch_ready_o,
    output logic                 fetch_data_valid_o,
    output data_t                fetch_data_o,
    output logic                 fetch_done_o,
    // data side
    input  logic                 mem_req_i,
    input  logic                 mem_we_i,
    input  addr_t                mem_addr_i,
    input  logic [MAX_LEN_W-1:0] mem_len_i,
    input  data_t                mem_wdata_i,
    input  strb_t                mem_wstrb_i,
    output logic                 mem_ready_o,
    output logic                 wdata_pull_o,
    output logic                 mem_rdata_valid_o,
    output data_t                mem_rdata_o,
    output logic                 mem_done_o,
    // AXI master
    output axi_id_t              arid_o,
    output addr_t                araddr_o,
    output axi_len_t             arlen_o,
    output logic                 arvalid_o,
    input  logic                 arready_i,
    input  axi_id_t              rid_i,
    input  data_t                rdata_i,
    input  logic                 rlast_i,
    input  logic                 rvalid_i,
    output logic                 rready_o,
    output axi_id_t              awid_o,
    output addr_t                awaddr_o,
    output axi_len_t             awlen_o,
    output logic                 awvalid_o,
    input  logic                 awready_i,
    output data_t                wdata_o,
    output strb_t                wstrb_o,
    output logic                 wlast_o,
    output logic                 wvalid_o,
    input  logic                 wready_i,
    input  axi_id_t              bid_i,
    input  logic                 bvalid_i,
    output logic                 bready_o
);

    logic     f_ar_valid, d_ar_valid;
    addr_t    f_ar_addr, d_ar_addr;
    axi_len_t f_ar_len, d_ar_len;
    logic     f_grant, d_grant;
    logic     f_beat_valid, d_beat_valid;
    data_t    f_beat_data, d_beat_data;
    logic     f_beat_last, d_beat_last;
    logic     b_hit;

    // only the data port writes
    assign awid_o   = ID_DATA;
    assign bready_o = 1'b1;
    assign b_hit    = bvalid_i & (bid_i == ID_DATA);

    refill_read_port #(.MAX_LEN_W(MAX_LEN_W)) u_refill (
        .aclk(aclk), .rst_n_i(rst_n_i),
        .fetch_req_i(fetch_req_i), .fetch_addr_i(fetch_addr_i),
        .fetch_len_i(fetch_len_i), .fetch_ready_o(fetch_ready_o),
        .fetch_data_valid_o(fetch_data_valid_o), .fetch_data_o(fetch_data_o),
        .fetch_done_o(fetch_done_o),
        .ar_valid_o(f_ar_valid), .ar_addr_o(f_ar_addr), .ar_len_o(f_ar_len),
        .ar_grant_i(f_grant), .beat_valid_i(f_beat_valid),
        .beat_data_i(f_beat_data), .beat_last_i(f_beat_last)
    );

    data_access_port #(.MAX_LEN_W(MAX_LEN_W)) u_data (
        .aclk(aclk), .rst_n_i(rst_n_i),
        .mem_req_i(mem_req_i), .mem_we_i(mem_we_i), .mem_addr_i(mem_addr_i),
        .mem_len_i(mem_len_i), .mem_wdata_i(mem_wdata_i), .mem_wstrb_i(mem_wstrb_i),
        .mem_ready_o(mem_ready_o), .wdata_pull_o(wdata_pull_o),
        .mem_rdata_valid_o(mem_rdata_valid_o), .mem_rdata_o(mem_rdata_o),
        .mem_done_o(mem_done_o),
        .ar_valid_o(d_ar_valid), .ar_addr_o(d_ar_addr), .ar_len_o(d_ar_len),
        .ar_grant_i(d_grant), .beat_valid_i(d_beat_valid),
        .beat_data_i(d_beat_data), .beat_last_i(d_beat_last),
        .awvalid_o(awvalid_o), .awaddr_o(awaddr_o), .awlen_o(awlen_o),
        .awready_i(awready_i), .wvalid_o(wvalid_o), .wdata_o(wdata_o),
        .wstrb_o(wstrb_o), .wlast_o(wlast_o), .wready_i(wready_i),
        .bvalid_i(b_hit)
    );

    axi_bus_mux u_mux (
        .aclk(aclk), .rst_n_i(rst_n_i),
        .fetch_ar_valid_i(f_ar_valid), .fetch_ar_addr_i(f_ar_addr),
        .fetch_ar_len_i(f_ar_len), .fetch_grant_o(f_grant),
        .fetch_beat_valid_o(f_beat_valid), .fetch_beat_data_o(f_beat_data),
        .fetch_beat_last_o(f_beat_last),
        .data_ar_valid_i(d_ar_valid), .data_ar_addr_i(d_ar_addr),
        .data_ar_len_i(d_ar_len), .data_grant_o(d_grant),
        .data_beat_valid_o(d_beat_valid), .data_beat_data_o(d_beat_data),
        .data_beat_last_o(d_beat_last),
        .arid_o(arid_o), .araddr_o(araddr_o), .arlen_o(arlen_o),
        .arvalid_o(arvalid_o), .arready_i(arready_i),
        .rid_i(rid_i), .rdata_i(rdata_i), .rlast_i(rlast_i),
        .rvalid_i(rvalid_i), .rready_o(rready_o)
    );

endmodule

// File: src/refill_read_port.sv
module refill_read_port import bridge_pkg::*; #(
    parameter int MAX_LEN_W = 4
) (
    input  logic                 aclk,
    input  logic                 rst_n_i,
    // icache refill side
    input  logic                 fetch_req_i,
    input  addr_t                fetch_addr_i,
    input  logic [MAX_LEN_W-1:0] fetch_len_i,
    output logic                 fetch_ready_o,
    output logic                 fetch_data_valid_o,
    output data_t                fetch_data_o,
    output logic                 fetch_done_o,
    // towards the mux
    output logic                 ar_valid_o,
    output addr_t                ar_addr_o,
    output axi_len_t             ar_len_o,
    input  logic                 ar_grant_i,
    input  logic                 beat_valid_i,
    input  data_t                beat_data_i,
    input  logic                 beat_last_i
);

    port_state_t          state_q;
    addr_t                addr_q;
    logic [MAX_LEN_W-1:0] len_q;
    logic                 in_data;

    assign fetch_ready_o = (state_q == IDLE);
    assign in_data       = (state_q == DATA);

    assign ar_valid_o = (state_q == ADDR);
    assign ar_addr_o  = addr_q;
    assign ar_len_o   = axi_len_t'(len_q); // zero extend to the bus field

    // beats go straight to the cache, no buffering
    assign fetch_data_valid_o = in_data & beat_valid_i;
    assign fetch_data_o       = beat_data_i;
    assign fetch_done_o       = in_data & beat_valid_i & beat_last_i;

    always_ff @(posedge aclk) begin
        if (fetch_req_i && fetch_ready_o) begin
            addr_q <= fetch_addr_i;
            len_q  <= fetch_len_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (fetch_req_i) state_q <= ADDR;
                ADDR:    if (ar_grant_i) state_q <= DATA;
                DATA:    if (fetch_done_o) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule
